//--- dv/spi_reg_tb.sv
`timescale 1ns/1ps

module spi_reg_tb;

    // SPI half period and select gap in clk cycles
    localparam int HALF = 6;
    localparam int GAP = 16;
    localparam int TIMEOUT_CYCLES = 40 * (56 * 12 + 40) + 2000;

    logic clk = 1'b0;
    logic nrst;
    logic spi_clk;
    logic spi_ss;
    logic spi_mosi;
    wire spi_miso;
    logic local_req;
    logic local_we;
    reg_pkg::reg_addr_t local_addr;
    reg_pkg::reg_data_t local_wdata;
    logic local_gnt;
    logic local_rvalid;
    reg_pkg::reg_data_t local_rdata;

    // Shadow of the register memory and the response due next
    reg_pkg::reg_data_t shadow [reg_pkg::REG_DEPTH];
    spi_cmd_pkg::resp_frame_t model_resp;
    int cycle_count = 0;
    int lost_count = 0;

    spi_reg_top uut (
        .clk(clk),
        .nrst(nrst),
        .spi_clk(spi_clk),
        .spi_ss(spi_ss),
        .spi_mosi(spi_mosi),
        .spi_miso(spi_miso),
        .local_req(local_req),
        .local_we(local_we),
        .local_addr(local_addr),
        .local_wdata(local_wdata),
        .local_gnt(local_gnt),
        .local_rvalid(local_rvalid),
        .local_rdata(local_rdata)
    );

    always #4 clk = ~clk;

    // ************************************************************
    // Failure handling and protocol checks
    // ************************************************************
    task automatic stop_run();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
            stop_run();
        end
    endtask

    assert property (@(posedge clk) disable iff (!nrst) local_gnt |-> local_req) else begin
        $display("Local grant given without a local request at %0t", $time);
        stop_run();
    end

    assert property (@(posedge clk) disable iff (!nrst)
            (local_gnt && !local_we) |=> local_rvalid) else begin
        $display("Local read data did not follow its grant by one cycle at %0t", $time);
        stop_run();
    end

    assert property (@(posedge clk) disable iff (!nrst)
            local_rvalid |-> $past(local_gnt && !local_we)) else begin
        $display("Local read data pulse without a read grant one cycle earlier at %0t", $time);
        stop_run();
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", TIMEOUT_CYCLES);
            stop_run();
        end
    end

    // ************************************************************
    // Stimulus helpers
    // ************************************************************
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic spi_cmd_pkg::cmd_frame_t read_frame(input reg_pkg::reg_addr_t addr);
        return {spi_cmd_pkg::OP_READ, 4'h0, addr, 40'h0};
    endfunction

    function automatic spi_cmd_pkg::cmd_frame_t write_frame(input reg_pkg::reg_addr_t addr,
                                                            input reg_pkg::reg_data_t data);
        return {spi_cmd_pkg::OP_WRITE, 4'h0, addr, data, 8'h0};
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Next response from the command rules
    task automatic predict(input spi_cmd_pkg::cmd_frame_t frame, input int nbits);
        logic [7:0] op;
        logic [7:0] addr;
        logic [31:0] data;
        int nbytes;
        logic ok;
        frame = frame & ~({56{1'b1}} >> nbits);
        op = frame[55:48];
        addr = frame[47:40];
        data = frame[39:8];
        nbytes = nbits / 8;
        // Partial bytes leave the response unchanged
        if (nbits % 8 != 0 || nbits == 0) begin
            return;
        end
        ok = ((op == spi_cmd_pkg::OP_READ && nbytes == int'(spi_cmd_pkg::LEN_READ))
            || (op == spi_cmd_pkg::OP_WRITE && nbytes == int'(spi_cmd_pkg::LEN_WRITE)))
            && addr < 8'(reg_pkg::REG_DEPTH);
        if (!ok) begin
            model_resp = {spi_cmd_pkg::ST_ERROR, addr, 32'h0};
        end else if (op == spi_cmd_pkg::OP_WRITE) begin
            model_resp = {spi_cmd_pkg::OP_WRITE, addr, data};
            shadow[addr[3:0]] = data;
        end else begin
            model_resp = {spi_cmd_pkg::OP_READ, addr, shadow[addr[3:0]]};
        end
    endtask

    // Mode 0 bit-bang with MSB first and miso sampled at each rising sck
    task automatic spi_xfer(input spi_cmd_pkg::cmd_frame_t frame, input int nbits);
        spi_cmd_pkg::resp_frame_t got;
        spi_cmd_pkg::resp_frame_t mask;
        got = '0;
        mask = (nbits >= 48) ? {48{1'b1}} : ~({48{1'b1}} >> nbits);
        spi_ss = 1'b0;
        for (int i = 0; i < nbits; i++) begin
            spi_mosi = frame[55 - i];
            wait_cycles(HALF);
            if (i < 48) begin
                got[47 - i] = spi_miso;
            end
            spi_clk = 1'b1;
            wait_cycles(HALF);
            spi_clk = 1'b0;
        end
        wait_cycles(HALF);
        spi_ss = 1'b1;
        check_value("spi_miso response", 64'(model_resp & mask), 64'(got & mask));
        predict(frame, nbits);
        wait_cycles(GAP);
    endtask

    // Holds the request until granted; called and returns just after a rising edge
    task automatic local_access(input logic we, input reg_pkg::reg_addr_t addr,
                                input reg_pkg::reg_data_t wdata);
        reg_pkg::reg_data_t expected;
        local_req = 1'b1;
        local_we = we;
        local_addr = addr;
        local_wdata = wdata;
        @(negedge clk);
        if (!local_gnt) begin
            lost_count++;
        end
        while (!local_gnt) begin
            @(negedge clk);
        end
        expected = shadow[addr];
        if (we) begin
            shadow[addr] = wdata;
        end
        @(posedge clk);
        #1;
        local_req = 1'b0;
        @(negedge clk);
        check_value("local_rvalid", 64'(!we), 64'(local_rvalid));
        if (!we) begin
            check_value("local_rdata", 64'(expected), 64'(local_rdata));
        end
        @(posedge clk);
        #1;
    endtask

    // ************************************************************
    // Test sequence
    // ************************************************************
    initial begin
        logic [31:0] rng;
        reg_pkg::reg_addr_t ra;
        reg_pkg::reg_data_t rd;
        nrst = 1'b0;
        spi_clk = 1'b0;
        spi_ss = 1'b1;
        spi_mosi = 1'b0;
        local_req = 1'b0;
        local_we = 1'b0;
        local_addr = '0;
        local_wdata = '0;
        model_resp = '0;
        rng = 32'hbb39;
        for (int i = 0; i < reg_pkg::REG_DEPTH; i++) begin
            shadow[i] = '0;
        end
        wait_cycles(4);
        nrst = 1'b1;
        wait_cycles(10);

        // Reset state, then pipelined write and read
        spi_xfer('0, 56);
        spi_xfer(write_frame(4'h5, 32'h1234_5678), 48);
        spi_xfer('0, 56);
        spi_xfer(read_frame(4'h5), 16);
        spi_xfer('0, 56);

        // Memory shared with the local port
        local_access(1'b0, 4'h5, '0);
        local_access(1'b1, 4'hc, 32'hcafe_0001);
        spi_xfer(read_frame(4'hc), 16);
        spi_xfer('0, 56);

        // Rejected commands; 8'h25 would alias entry 5 if truncated
        spi_xfer({8'h07, 8'h03, 40'h0}, 16);
        spi_xfer({spi_cmd_pkg::OP_READ, 8'h03, 40'h0}, 24);
        spi_xfer({spi_cmd_pkg::OP_READ, 8'h10, 40'h0}, 16);
        spi_xfer({spi_cmd_pkg::OP_WRITE, 8'h25, 32'hdead_beef, 8'h0}, 48);
        spi_xfer(read_frame(4'h5), 16);
        spi_xfer({spi_cmd_pkg::OP_WRITE, 8'h05, 40'h0}, 20);
        spi_xfer('0, 56);

        // Local requests start in the cycle the engine requests
        fork
            begin
                spi_xfer(write_frame(4'h3, 32'h0bad_f00d), 48);
                spi_xfer(read_frame(4'h9), 16);
                spi_xfer(write_frame(4'h9, 32'h7777_1111), 48);
                spi_xfer('0, 56);
            end
            begin
                for (int i = 0; i < 3; i++) begin
                    do begin
                        @(negedge clk);
                    end while (!uut.valid);
                    @(posedge clk);
                    #1;
                    local_access(i == 1, (i == 0) ? 4'h3 : 4'h9, 32'h5555_aaaa);
                end
            end
        join
        assert (lost_count > 0) else begin
            $display("Local port never collided with an SPI request");
            stop_run();
        end

        // Random mix checked against the shadow
        for (int i = 0; i < 30; i++) begin
            rng = xorshift(rng);
            ra = rng[5:2];
            case (rng[1:0])
                2'd0: begin
                    rng = xorshift(rng);
                    rd = rng;
                    spi_xfer(write_frame(ra, rd), 48);
                end
                2'd1: spi_xfer(read_frame(ra), 16);
                2'd2: begin
                    rng = xorshift(rng);
                    rd = rng;
                    local_access(1'b1, ra, rd);
                end
                default: local_access(1'b0, ra, '0);
            endcase
        end
        spi_xfer('0, 56);

        $display("Verification passed");
        $finish;
    end

endmodule

//--- hdl/reg_arbiter.sv
`timescale 1ns/1ps

module reg_arbiter (
    input  logic clk,
    input  logic nrst,

    input  logic spi_req,
    input  logic spi_we,
    input  reg_pkg::reg_addr_t spi_addr,
    input  reg_pkg::reg_data_t spi_wdata,
    output logic spi_gnt,
    output logic spi_rvalid,
    output reg_pkg::reg_data_t spi_rdata,

    input  logic local_req,
    input  logic local_we,
    input  reg_pkg::reg_addr_t local_addr,
    input  reg_pkg::reg_data_t local_wdata,
    output logic local_gnt,
    output logic local_rvalid,
    output reg_pkg::reg_data_t local_rdata,

    output logic mem_en,
    output logic mem_we,
    output reg_pkg::reg_addr_t mem_addr,
    output reg_pkg::reg_data_t mem_wdata,
    input  reg_pkg::reg_data_t mem_rdata
);

    logic [reg_pkg::REQ_COUNT-1:0] gnt;
    logic [reg_pkg::REQ_COUNT-1:0] rd_vld;

    // Fixed priority, SPI first
    assign gnt[reg_pkg::REQ_SPI] = spi_req;
    assign gnt[reg_pkg::REQ_LOCAL] = local_req & ~spi_req;

    assign spi_gnt = gnt[reg_pkg::REQ_SPI];
    assign local_gnt = gnt[reg_pkg::REQ_LOCAL];

    // Steer the winner to the memory
    assign mem_en = |gnt;
    assign mem_we = gnt[reg_pkg::REQ_SPI] ? spi_we : local_we;
    assign mem_addr = gnt[reg_pkg::REQ_SPI] ? spi_addr : local_addr;
    assign mem_wdata = gnt[reg_pkg::REQ_SPI] ? spi_wdata : local_wdata;

    // Track read owner for the returning data
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rd_vld <= '0;
        end else begin
            rd_vld <= gnt & {reg_pkg::REQ_COUNT{~mem_we}};
        end
    end

    assign spi_rvalid = rd_vld[reg_pkg::REQ_SPI];
    assign local_rvalid = rd_vld[reg_pkg::REQ_LOCAL];
    assign spi_rdata = mem_rdata;
    assign local_rdata = mem_rdata;

endmodule

//--- hdl/reg_mem.sv
`timescale 1ns/1ps

module reg_mem (
    input  logic clk,
    input  logic nrst,
    input  logic mem_en,
    input  logic mem_we,
    input  reg_pkg::reg_addr_t mem_addr,
    input  reg_pkg::reg_data_t mem_wdata,
    output reg_pkg::reg_data_t mem_rdata
);

    reg_pkg::reg_data_t regs [reg_pkg::REG_DEPTH];

    // Registers come up cleared
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < reg_pkg::REG_DEPTH; i++) begin
                regs[i] <= '0;
            end
            mem_rdata <= '0;
        end else if (mem_en) begin
            if (mem_we) begin
                regs[mem_addr] <= mem_wdata;
            end else begin
                mem_rdata <= regs[mem_addr];
            end
        end
    end

endmodule

//--- hdl/reg_pkg.sv
package reg_pkg;

    // Register file geometry
    localparam int REG_DEPTH = 16;
    localparam int REG_DATA_W = 32;

    typedef logic [$clog2(REG_DEPTH)-1:0] reg_addr_t;
    typedef logic [REG_DATA_W-1:0] reg_data_t;

    // Requester slots in the arbiter
    localparam int REQ_SPI = 0;
    localparam int REQ_LOCAL = 1;

    // Number of requesters sharing the memory
    localparam int REQ_COUNT = 2;

endpackage

//--- hdl/spi_cmd_engine.sv
`timescale 1ns/1ps

module spi_cmd_engine (
    input  logic clk,
    input  logic nrst,

    input  spi_cmd_pkg::cmd_frame_t cmd_read,
    input  spi_cmd_pkg::cmd_len_t cmd_len_bytes,
    input  logic valid,
    output spi_cmd_pkg::resp_frame_t cmd_write,

    output logic spi_req,
    output logic spi_we,
    output reg_pkg::reg_addr_t spi_addr,
    output reg_pkg::reg_data_t spi_wdata,
    input  logic spi_gnt,
    input  logic spi_rvalid,
    input  reg_pkg::reg_data_t rdata
);

    spi_cmd_pkg::engine_state_t state;
    spi_cmd_pkg::cmd_frame_t aligned;
    spi_cmd_pkg::cmd_len_t pad_bytes;
    spi_cmd_pkg::op_t cmd_op;
    logic [7:0] cmd_addr_byte;
    reg_pkg::reg_data_t cmd_data;
    logic len_ok;
    logic addr_ok;
    logic cmd_ok;

    // ***********************************************************
    // Decode
    // ***********************************************************
    // Move the first received byte to the top of the frame
    assign pad_bytes = 3'd7 - cmd_len_bytes;

    always_comb begin
        aligned = cmd_read << {pad_bytes, 3'b000};
        cmd_op = aligned[55:48];
        cmd_addr_byte = aligned[47:40];
        cmd_data = aligned[39:8];
    end

    // Opcode must be known and match its byte count
    assign len_ok = (cmd_op == spi_cmd_pkg::OP_READ && cmd_len_bytes == spi_cmd_pkg::LEN_READ)
        || (cmd_op == spi_cmd_pkg::OP_WRITE && cmd_len_bytes == spi_cmd_pkg::LEN_WRITE);
    assign addr_ok = cmd_addr_byte < 8'(reg_pkg::REG_DEPTH);
    assign cmd_ok = len_ok && addr_ok;

    // ***********************************************************
    // Request and response FSM
    // ***********************************************************
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= spi_cmd_pkg::ENG_IDLE;
            spi_req <= 1'b0;
            cmd_write <= '0;
        end else begin
            case (state)
                spi_cmd_pkg::ENG_IDLE: begin
                    if (valid && cmd_ok) begin
                        spi_req <= 1'b1;
                        state <= spi_cmd_pkg::ENG_REQ;
                    end else if (valid) begin
                        cmd_write <= {spi_cmd_pkg::ST_ERROR, cmd_addr_byte, 32'h0};
                    end
                end
                spi_cmd_pkg::ENG_REQ: begin
                    if (spi_gnt) begin
                        spi_req <= 1'b0;
                        if (spi_we) begin
                            cmd_write <= {spi_cmd_pkg::OP_WRITE, 8'(spi_addr), spi_wdata};
                            state <= spi_cmd_pkg::ENG_IDLE;
                        end else begin
                            state <= spi_cmd_pkg::ENG_WAIT;
                        end
                    end
                end
                spi_cmd_pkg::ENG_WAIT: begin
                    // Read data returns one cycle after grant
                    if (spi_rvalid) begin
                        cmd_write <= {spi_cmd_pkg::OP_READ, 8'(spi_addr), rdata};
                        state <= spi_cmd_pkg::ENG_IDLE;
                    end
                end
                default: state <= spi_cmd_pkg::ENG_IDLE;
            endcase
        end
    end

    // Request fields held for the whole command
    always_ff @(posedge clk) begin
        if (state == spi_cmd_pkg::ENG_IDLE && valid && cmd_ok) begin
            spi_we <= (cmd_op == spi_cmd_pkg::OP_WRITE);
            spi_addr <= reg_pkg::reg_addr_t'(cmd_addr_byte);
            spi_wdata <= cmd_data;
        end
    end

endmodule

//--- hdl/spi_cmd_pkg.sv
package spi_cmd_pkg;

    // ***********************************************************
    // Frame widths
    // ***********************************************************
    localparam int CMD_BYTES = 7;
    localparam int RESP_BYTES = 6;
    localparam int CMD_BITS = CMD_BYTES * 8;
    localparam int RESP_BITS = RESP_BYTES * 8;

    // Last received byte sits in bits 7:0
    typedef logic [CMD_BITS-1:0] cmd_frame_t;
    // Status, address, then data MSB first
    typedef logic [RESP_BITS-1:0] resp_frame_t;
    typedef logic [2:0] cmd_len_t;
    typedef logic [7:0] op_t;

    // ***********************************************************
    // Opcodes and status
    // ***********************************************************
    localparam op_t OP_READ = 8'h01;
    localparam op_t OP_WRITE = 8'h02;
    localparam op_t ST_ERROR = 8'hEE;

    // Opcode + address, opcode + address + 4 data bytes
    localparam cmd_len_t LEN_READ = 3'd2;
    localparam cmd_len_t LEN_WRITE = 3'd6;

    typedef enum logic [1:0] {ENG_IDLE, ENG_REQ, ENG_WAIT} engine_state_t;

endpackage

//--- hdl/spi_iff.sv
`timescale 1ns/1ps

module spi_iff (
    input  logic clk,
    input  logic nrst,

    input  logic spi_clk,
    input  logic spi_ss,
    input  logic spi_mosi,
    output logic spi_miso,

    output spi_cmd_pkg::cmd_frame_t cmd_read,
    output spi_cmd_pkg::cmd_len_t cmd_len_bytes,
    input  spi_cmd_pkg::resp_frame_t cmd_write,
    output logic valid
);

    spi_cmd_pkg::cmd_frame_t in_reg;
    spi_cmd_pkg::resp_frame_t out_reg;
    logic [5:0] cmd_len_bits;

    logic sync_mosi;
    logic sync_sck;
    logic sync_ss;
    logic last_sck;
    logic last_ss;
    logic posedge_sck;
    logic negedge_sck;
    logic posedge_ss;
    logic negedge_ss;

    // ***********************************************************
    // Input synchronizers and edge detect
    // ***********************************************************
    sync_sig u_sync_mosi (
        .clk(clk),
        .nrst(nrst),
        .in_sig(spi_mosi),
        .out_sig(sync_mosi)
    );

    sync_sig u_sync_sck (
        .clk(clk),
        .nrst(nrst),
        .in_sig(spi_clk),
        .out_sig(sync_sck)
    );

    sync_sig u_sync_ss (
        .clk(clk),
        .nrst(nrst),
        .in_sig(spi_ss),
        .out_sig(sync_ss)
    );

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            last_sck <= 1'b0;
            last_ss <= 1'b1;
        end else begin
            last_sck <= sync_sck;
            last_ss <= sync_ss;
        end
    end

    assign posedge_sck = ~last_sck & sync_sck;
    assign negedge_sck = last_sck & ~sync_sck;
    assign posedge_ss = ~last_ss & sync_ss;
    assign negedge_ss = last_ss & ~sync_ss;

    // Tristate while deselected
    assign spi_miso = sync_ss ? 1'bz : out_reg[spi_cmd_pkg::RESP_BITS-1];
    assign cmd_len_bytes = cmd_len_bits[5:3];

    // ***********************************************************
    // Command capture and bit count
    // ***********************************************************
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            in_reg <= '0;
            cmd_len_bits <= '0;
        end else if (negedge_ss) begin
            in_reg <= '0;
            cmd_len_bits <= '0;
        end else if (posedge_sck) begin
            in_reg <= {in_reg[spi_cmd_pkg::CMD_BITS-2:0], sync_mosi};
            cmd_len_bits <= cmd_len_bits + 6'd1;
        end
    end

    // Response loads on select, shifts on falling sck
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            out_reg <= '0;
        end else if (negedge_ss) begin
            out_reg <= cmd_write;
        end else if (posedge_ss) begin
            out_reg <= '0;
        end else if (!sync_ss && negedge_sck) begin
            out_reg <= {out_reg[spi_cmd_pkg::RESP_BITS-2:0], 1'b0};
        end
    end

    // Hand the frame over at end of select
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            cmd_read <= '0;
            valid <= 1'b0;
        end else begin
            valid <= 1'b0;
            if (posedge_ss) begin
                cmd_read <= in_reg;
                // Empty frame (e.g. select settling after reset) is ignored
                valid <= (cmd_len_bits[2:0] == 3'd0) && (cmd_len_bits != 6'd0);
            end
        end
    end

endmodule

//--- hdl/spi_reg_top.sv
`timescale 1ns/1ps

module spi_reg_top (
    input  logic clk,
    input  logic nrst,

    input  logic spi_clk,
    input  logic spi_ss,
    input  logic spi_mosi,
    output logic spi_miso,

    input  logic local_req,
    input  logic local_we,
    input  reg_pkg::reg_addr_t local_addr,
    input  reg_pkg::reg_data_t local_wdata,
    output logic local_gnt,
    output logic local_rvalid,
    output reg_pkg::reg_data_t local_rdata
);

    spi_cmd_pkg::cmd_frame_t cmd_read;
    spi_cmd_pkg::cmd_len_t cmd_len_bytes;
    spi_cmd_pkg::resp_frame_t cmd_write;
    logic valid;

    logic spi_req;
    logic spi_we;
    reg_pkg::reg_addr_t spi_addr;
    reg_pkg::reg_data_t spi_wdata;
    logic spi_gnt;
    logic spi_rvalid;
    reg_pkg::reg_data_t spi_rdata;

    logic mem_en;
    logic mem_we;
    reg_pkg::reg_addr_t mem_addr;
    reg_pkg::reg_data_t mem_wdata;
    reg_pkg::reg_data_t mem_rdata;

    // SPI slave front end
    spi_iff u_spi_iff (
        .clk(clk),
        .nrst(nrst),
        .spi_clk(spi_clk),
        .spi_ss(spi_ss),
        .spi_mosi(spi_mosi),
        .spi_miso(spi_miso),
        .cmd_read(cmd_read),
        .cmd_len_bytes(cmd_len_bytes),
        .cmd_write(cmd_write),
        .valid(valid)
    );

    spi_cmd_engine u_engine (
        .clk(clk),
        .nrst(nrst),
        .cmd_read(cmd_read),
        .cmd_len_bytes(cmd_len_bytes),
        .valid(valid),
        .cmd_write(cmd_write),
        .spi_req(spi_req),
        .spi_we(spi_we),
        .spi_addr(spi_addr),
        .spi_wdata(spi_wdata),
        .spi_gnt(spi_gnt),
        .spi_rvalid(spi_rvalid),
        .rdata(spi_rdata)
    );

    // Shared memory access
    reg_arbiter u_arbiter (
        .clk(clk),
        .nrst(nrst),
        .spi_req(spi_req),
        .spi_we(spi_we),
        .spi_addr(spi_addr),
        .spi_wdata(spi_wdata),
        .spi_gnt(spi_gnt),
        .spi_rvalid(spi_rvalid),
        .spi_rdata(spi_rdata),
        .local_req(local_req),
        .local_we(local_we),
        .local_addr(local_addr),
        .local_wdata(local_wdata),
        .local_gnt(local_gnt),
        .local_rvalid(local_rvalid),
        .local_rdata(local_rdata),
        .mem_en(mem_en),
        .mem_we(mem_we),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata)
    );

    reg_mem u_mem (
        .clk(clk),
        .nrst(nrst),
        .mem_en(mem_en),
        .mem_we(mem_we),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata)
    );

endmodule

//--- hdl/sync_sig.sv
`timescale 1ns/1ps

module sync_sig (
    input  logic clk,
    input  logic nrst,
    input  logic in_sig,
    output logic out_sig
);

    logic meta;

    // Two flops against metastability
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            meta <= 1'b0;
            out_sig <= 1'b0;
        end else begin
            meta <= in_sig;
            out_sig <= meta;
        end
    end

endmodule

//--- project.f
hdl/spi_cmd_pkg.sv
hdl/reg_pkg.sv
hdl/sync_sig.sv
hdl/spi_iff.sv
hdl/spi_cmd_engine.sv
hdl/reg_arbiter.sv
hdl/reg_mem.sv
hdl/spi_reg_top.sv
dv/spi_reg_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module spi_reg_tb \
    --Mdir obj_dir -o spi_reg_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/spi_reg_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

exit 0
